// File: source/bridge_pkg.sv
// Shared word, field and segment types plus command word field positions

package bridge_pkg;

	// ====================
	// Word and field types
	// ====================

	// One FIFO word, both directions
	typedef logic [31:0] fifo_word_t;

	// Command number, low nibble of the word
	typedef logic [3:0] cmd_t;

	// X or y argument
	typedef logic [13:0] coord_t;

	// Seven-segment pattern
	// Active low, bit 0 drives segment a, bit 6 segment g
	typedef logic [6:0] seg_t;

	// ====================
	// Field positions
	// ====================

	// Word layout, LSB first
	//   [3:0]   command
	//   [17:4]  x argument
	//   [31:18] y argument
	parameter int CMD_LSB = 0;
	parameter int X_LSB = 4;
	parameter int Y_LSB = 18;

endpackage : bridge_pkg

// File: source/hex_digit.sv
// Active-low seven-segment decoder for one hex nibble

`timescale 1ns/1ps

module hex_digit (
	input  logic [3:0]       nibble,
	output bridge_pkg::seg_t segments
);

	// Bit order g f e d c b a, zero lights the segment
	always_comb begin
		case (nibble)
			4'h0: segments = 7'b1000000;
			4'h1: segments = 7'b1111001;
			4'h2: segments = 7'b0100100;
			4'h3: segments = 7'b0110000;
			4'h4: segments = 7'b0011001;
			4'h5: segments = 7'b0010010;
			4'h6: segments = 7'b0000010;
			4'h7: segments = 7'b1111000;
			4'h8: segments = 7'b0000000;
			4'h9: segments = 7'b0010000;
			// Letters, b and d in lower case
			4'hA: segments = 7'b0001000;
			4'hB: segments = 7'b0000011;
			4'hC: segments = 7'b1000110;
			4'hD: segments = 7'b0100001;
			4'hE: segments = 7'b0000110;
			4'hF: segments = 7'b0001110;
			default: segments = 7'b1111111;
		endcase
	end

endmodule : hex_digit

// File: source/hps_fifo_reader.sv
// HPS-to-FPGA FIFO read state machine, word buffer and buffer-valid flag

`timescale 1ns/1ps

module hps_fifo_reader (
	input  logic                   CLOCK_50,
	input  logic                   rst_n,
	input  logic                   rx_empty,
	input  bridge_pkg::fifo_word_t rx_data,
	input  logic                   echo_taken,
	output logic                   rx_read,
	output bridge_pkg::fifo_word_t cmd_word,
	output logic                   cmd_valid,
	output logic                   echo_valid
);

	// ====================
	// Read state machine
	// ====================

	typedef enum logic [1:0] {
		AWAIT,
		DELAY_READ,
		READ,
		DELAY_AWAIT
	} reader_state_t;

	reader_state_t state;

	// One word in flight at a time
	// echo_valid doubles as the buffer-full flag that blocks new reads
	always_ff @(posedge CLOCK_50 or negedge rst_n) begin
		if (!rst_n) begin
			state <= AWAIT;
			rx_read <= 1'b0;
			cmd_valid <= 1'b0;
			echo_valid <= 1'b0;
		end else begin
			// Single-cycle strobe by default
			cmd_valid <= 1'b0;

			// Writer has copied the buffer out
			if (echo_taken) begin
				echo_valid <= 1'b0;
			end

			case (state)
				AWAIT: begin
					// Word waiting and buffer free
					if (!rx_empty && !echo_valid) begin
						rx_read <= 1'b1;
						state <= DELAY_READ;
					end
				end
				DELAY_READ: begin
					// Drop the pop strobe before the data shows up
					rx_read <= 1'b0;
					state <= READ;
				end
				READ: begin
					// rx_data settled, buffer loads below
					state <= DELAY_AWAIT;
				end
				DELAY_AWAIT: begin
					// Hand the word to writer and display
					echo_valid <= 1'b1;
					cmd_valid <= 1'b1;
					state <= AWAIT;
				end
				default: begin
					state <= AWAIT;
				end
			endcase
		end
	end

	// ====================
	// Word buffer
	// ====================

	// Captured two cycles after the pop
	always_ff @(posedge CLOCK_50) begin
		if (state == READ) begin
			cmd_word <= rx_data;
		end
	end

endmodule : hps_fifo_reader

// File: source/hps_fifo_writer.sv
// FPGA-to-HPS FIFO write state machine with full-level stall

`timescale 1ns/1ps

module hps_fifo_writer (
	input  logic                   CLOCK_50,
	input  logic                   rst_n,
	input  logic                   echo_valid,
	input  bridge_pkg::fifo_word_t echo_word,
	input  logic                   tx_full,
	output logic                   echo_taken,
	output bridge_pkg::fifo_word_t tx_data,
	output logic                   tx_write
);

	// ====================
	// Write state machine
	// ====================

	typedef enum logic [1:0] {
		IDLE,
		WRITE,
		DONE
	} writer_state_t;

	writer_state_t state;

	// Push only when space exists
	// The reader keeps its buffer while tx_full holds us in IDLE
	wire start_write = (state == IDLE) && echo_valid && !tx_full;

	always_ff @(posedge CLOCK_50 or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
			tx_write <= 1'b0;
			echo_taken <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					if (start_write) begin
						tx_write <= 1'b1;
						state <= WRITE;
					end
				end
				WRITE: begin
					// One push only, then release the buffer
					tx_write <= 1'b0;
					echo_taken <= 1'b1;
					state <= DONE;
				end
				DONE: begin
					// echo_valid drops on this edge
					echo_taken <= 1'b0;
					state <= IDLE;
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// Outgoing data, loaded with the strobe
	always_ff @(posedge CLOCK_50) begin
		if (start_write) begin
			tx_data <= echo_word;
		end
	end

endmodule : hps_fifo_writer

// File: source/command_display.sv
// Command word unpacking, command counter, LED and six-digit display drive

`timescale 1ns/1ps

module command_display (
	input  logic                   CLOCK_50,
	input  logic                   rst_n,
	input  logic                   cmd_valid,
	input  bridge_pkg::fifo_word_t cmd_word,
	output logic [3:0]             ledr,
	output bridge_pkg::seg_t       hex0,
	output bridge_pkg::seg_t       hex1,
	output bridge_pkg::seg_t       hex2,
	output bridge_pkg::seg_t       hex3,
	output bridge_pkg::seg_t       hex4,
	output bridge_pkg::seg_t       hex5
);

	import bridge_pkg::*;

	// ====================
	// Latched fields
	// ====================

	cmd_t       cmd_q;
	coord_t     x_q;
	coord_t     y_q;
	logic [3:0] cmd_count;

	// Unpack on the buffer strobe
	// Counter wraps after 16 commands
	always_ff @(posedge CLOCK_50 or negedge rst_n) begin
		if (!rst_n) begin
			cmd_q <= '0;
			x_q <= '0;
			y_q <= '0;
			cmd_count <= 4'd0;
		end else if (cmd_valid) begin
			cmd_q <= cmd_word[CMD_LSB +: $bits(cmd_t)];
			x_q <= cmd_word[X_LSB +: $bits(coord_t)];
			y_q <= cmd_word[Y_LSB +: $bits(coord_t)];
			cmd_count <= cmd_count + 4'd1;
		end
	end

	// Command on the low LEDs
	assign ledr = cmd_q;

	// ====================
	// Digits
	// ====================

	// Command and count on the right
	hex_digit u_hex0 (.nibble(cmd_q), .segments(hex0));
	hex_digit u_hex1 (.nibble(cmd_count), .segments(hex1));

	// Low byte of x
	hex_digit u_hex2 (.nibble(x_q[3:0]), .segments(hex2));
	hex_digit u_hex3 (.nibble(x_q[7:4]), .segments(hex3));

	// Low byte of y
	hex_digit u_hex4 (.nibble(y_q[3:0]), .segments(hex4));
	hex_digit u_hex5 (.nibble(y_q[7:4]), .segments(hex5));

endmodule : command_display

// File: source/command_bridge_top.sv
// Top level joining FIFO reader, FIFO writer and command display

`timescale 1ns/1ps

module command_bridge_top (
	input  logic                   CLOCK_50,
	input  logic                   rst_n,
	// HPS-to-FPGA FIFO
	input  bridge_pkg::fifo_word_t rx_data,
	input  logic                   rx_empty,
	output logic                   rx_read,
	// FPGA-to-HPS FIFO
	input  logic                   tx_full,
	output bridge_pkg::fifo_word_t tx_data,
	output logic                   tx_write,
	// Board outputs
	output logic [3:0]             ledr,
	output bridge_pkg::seg_t       hex0,
	output bridge_pkg::seg_t       hex1,
	output bridge_pkg::seg_t       hex2,
	output bridge_pkg::seg_t       hex3,
	output bridge_pkg::seg_t       hex4,
	output bridge_pkg::seg_t       hex5
);

	import bridge_pkg::*;

	// ====================
	// Internal links
	// ====================

	fifo_word_t cmd_word;
	logic       cmd_valid;
	logic       echo_valid;
	logic       echo_taken;

	// Pops one word, holds it until echoed
	hps_fifo_reader u_reader (
		.CLOCK_50   (CLOCK_50),
		.rst_n      (rst_n),
		.rx_empty   (rx_empty),
		.rx_data    (rx_data),
		.echo_taken (echo_taken),
		.rx_read    (rx_read),
		.cmd_word   (cmd_word),
		.cmd_valid  (cmd_valid),
		.echo_valid (echo_valid)
	);

	// Echo path back to the HPS
	hps_fifo_writer u_writer (
		.CLOCK_50   (CLOCK_50),
		.rst_n      (rst_n),
		.echo_valid (echo_valid),
		.echo_word  (cmd_word),
		.tx_full    (tx_full),
		.echo_taken (echo_taken),
		.tx_data    (tx_data),
		.tx_write   (tx_write)
	);

	// LEDs and seven-segment digits
	command_display u_display (
		.CLOCK_50  (CLOCK_50),
		.rst_n     (rst_n),
		.cmd_valid (cmd_valid),
		.cmd_word  (cmd_word),
		.ledr      (ledr),
		.hex0      (hex0),
		.hex1      (hex1),
		.hex2      (hex2),
		.hex3      (hex3),
		.hex4      (hex4),
		.hex5      (hex5)
	);

endmodule : command_bridge_top

// File: sim/command_bridge_tb.sv
// Testbench with FIFO models, trace reader, compare tasks and timeout

`timescale 1ns/1ps

module command_bridge_tb;

	import bridge_pkg::*;

	// ====================
	// DUT signals
	// ====================

	logic       CLOCK_50 = 1'b0;
	logic       rst_n = 1'b0;
	fifo_word_t rx_data = '0;
	logic       rx_empty = 1'b1;
	logic       tx_full = 1'b0;
	logic       rx_read;
	fifo_word_t tx_data;
	logic       tx_write;
	logic [3:0] ledr;
	seg_t       hex0;
	seg_t       hex1;
	seg_t       hex2;
	seg_t       hex3;
	seg_t       hex4;
	seg_t       hex5;

	// Trace contents and FIFO model state
	fifo_word_t trace_words[$];
	int         trace_holds[$];
	fifo_word_t rx_q[$];
	fifo_word_t popped_word = '0;
	fifo_word_t word_in;
	string      line;
	int         fd;
	int         hold_in;
	int         n_words = 0;
	int         max_hold = 0;
	int         cycle_limit = 100;
	int         cycle_count = 0;
	int         pop_count = 0;
	int         write_count = 0;
	int         full_count = 0;
	int         gap_count = 0;
	logic       started = 1'b0;
	logic       load_data = 1'b0;
	logic       in_flight = 1'b0;

	// Error counts per kind of check
	int word_errors = 0;
	int cmd_errors = 0;
	int seg_errors = 0;
	int protocol_errors = 0;

	// 40 ns period
	always #20 CLOCK_50 = ~CLOCK_50;

	command_bridge_top dut0 (
		.CLOCK_50 (CLOCK_50),
		.rst_n    (rst_n),
		.rx_data  (rx_data),
		.rx_empty (rx_empty),
		.rx_read  (rx_read),
		.tx_full  (tx_full),
		.tx_data  (tx_data),
		.tx_write (tx_write),
		.ledr     (ledr),
		.hex0     (hex0),
		.hex1     (hex1),
		.hex2     (hex2),
		.hex3     (hex3),
		.hex4     (hex4),
		.hex5     (hex5)
	);

	// ====================
	// Reference and compares
	// ====================

	// Lit segments as gfedcba, inverted for the active-low pins
	function automatic seg_t segments_for(input logic [3:0] value);
		logic [6:0] lit;
		case (value)
			4'h0: lit = 7'h3F;
			4'h1: lit = 7'h06;
			4'h2: lit = 7'h5B;
			4'h3: lit = 7'h4F;
			4'h4: lit = 7'h66;
			4'h5: lit = 7'h6D;
			4'h6: lit = 7'h7D;
			4'h7: lit = 7'h07;
			4'h8: lit = 7'h7F;
			4'h9: lit = 7'h6F;
			4'hA: lit = 7'h77;
			4'hB: lit = 7'h7C;
			4'hC: lit = 7'h39;
			4'hD: lit = 7'h5E;
			4'hE: lit = 7'h79;
			default: lit = 7'h71;
		endcase
		return ~lit;
	endfunction

	task automatic check_word(input string name, input fifo_word_t got, input fifo_word_t exp);
		if (got !== exp) begin
			word_errors++;
			$display("** Error %s: got %h, expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_cmd(input string name, input cmd_t got, input cmd_t exp);
		if (got !== exp) begin
			cmd_errors++;
			$display("** Error %s: got %h, expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_seg(input string name, input seg_t got, input seg_t exp);
		if (got !== exp) begin
			seg_errors++;
			$display("** Error %s: got %h, expected %h at %0t", name, got, exp, $time);
		end
	endtask

	// LEDs and all six digits against one set of fields
	task automatic compare_display(input cmd_t cmd, input logic [3:0] count,
		input coord_t x, input coord_t y);
		check_cmd("ledr", ledr, cmd);
		check_seg("hex0", hex0, segments_for(cmd));
		check_seg("hex1", hex1, segments_for(count));
		check_seg("hex2", hex2, segments_for(x[3:0]));
		check_seg("hex3", hex3, segments_for(x[7:4]));
		check_seg("hex4", hex4, segments_for(y[3:0]));
		check_seg("hex5", hex5, segments_for(y[7:4]));
	endtask

	// Echoed word in trace order, display already updated
	task automatic verify_echo();
		fifo_word_t exp_word;
		if (write_count >= n_words) begin
			protocol_errors++;
			$display("More words echoed than the trace holds at %0t", $time);
		end else begin
			exp_word = trace_words[write_count];
			check_word("tx_data", tx_data, exp_word);
			check_word("tx_data vs popped", tx_data, popped_word);
			compare_display(exp_word[CMD_LSB +: $bits(cmd_t)], 4'(write_count + 1),
				exp_word[X_LSB +: $bits(coord_t)], exp_word[Y_LSB +: $bits(coord_t)]);
		end
	endtask

	// Word and hold per line, hash lines skipped
	task automatic read_trace();
		fd = $fopen("sim/command_bridge_trace.txt", "r");
		if (fd == 0) begin
			protocol_errors++;
			$display("Trace file could not be opened");
		end else begin
			while (!$feof(fd)) begin
				line = "";
				if ($fgets(line, fd) != 0 && line.len() > 0 && line[0] != "#") begin
					if ($sscanf(line, "%h %d", word_in, hold_in) == 2) begin
						trace_words.push_back(word_in);
						trace_holds.push_back(hold_in);
						rx_q.push_back(word_in);
						if (hold_in > max_hold) begin
							max_hold = hold_in;
						end
					end
				end
			end
			$fclose(fd);
		end
		n_words = trace_words.size();
	endtask

	// ====================
	// FIFO models and protocol monitor
	// ====================

	// Checks first, using the levels the DUT saw at the last rising edge
	always @(negedge CLOCK_50) begin
		if (rst_n) begin
			if (rx_read && rx_empty) begin
				protocol_errors++;
				$display("rx_read while the receive FIFO was empty at %0t", $time);
			end
			if (rx_read && tx_full) begin
				protocol_errors++;
				$display("rx_read while tx_full was held at %0t", $time);
			end
			if (tx_write && tx_full) begin
				protocol_errors++;
				$display("tx_write while tx_full was held at %0t", $time);
			end
			// Head word appears one cycle after the pop
			if (load_data) begin
				rx_data = popped_word;
				load_data = 1'b0;
			end
			if (rx_read) begin
				if (in_flight) begin
					protocol_errors++;
					$display("Second rx_read before the previous word was echoed at %0t", $time);
				end
				if (rx_q.size() != 0) begin
					popped_word = rx_q.pop_front();
					load_data = 1'b1;
					full_count = trace_holds[pop_count];
					pop_count++;
				end
				in_flight = 1'b1;
			end
			if (tx_write) begin
				if (!in_flight) begin
					protocol_errors++;
					$display("tx_write with no word popped at %0t", $time);
				end
				verify_echo();
				write_count++;
				in_flight = 1'b0;
				gap_count = $urandom % 4;
			end else if (gap_count > 0) begin
				gap_count--;
			end
			// Full level counts down once per cycle
			tx_full = (full_count > 0);
			if (full_count > 0) begin
				full_count--;
			end
			rx_empty = !started || rx_q.size() == 0 || gap_count > 0;
		end
	end

	// Run limit from trace length
	always @(posedge CLOCK_50) begin
		cycle_count++;
		if (cycle_count > cycle_limit) begin
			$display("Timeout after %0d cycles with %0d of %0d words echoed",
				cycle_count, write_count, n_words);
			$display(">>> FAIL");
			$finish;
		end
	end

	// ====================
	// Main sequence
	// ====================

	initial begin
		void'($urandom(32'ha545_b23c));
		read_trace();
		cycle_limit = 8 + n_words * (max_hold + 20) + 100;
		repeat (8) @(negedge CLOCK_50);
		rst_n = 1'b1;
		// Idle bridge with nothing queued
		repeat (10) begin
			@(negedge CLOCK_50);
			if (rx_read || tx_write) begin
				protocol_errors++;
				$display("FIFO strobe active with an empty FIFO after reset at %0t", $time);
			end
			compare_display(4'h0, 4'h0, '0, '0);
		end
		// Released between falling edges so the FIFO model sees it next time
		@(posedge CLOCK_50);
		started = 1'b1;
		wait (write_count == n_words);
		repeat (5) @(negedge CLOCK_50);
		if (pop_count != n_words || rx_q.size() != 0) begin
			protocol_errors++;
			$display("Only %0d of %0d words were read", pop_count, n_words);
		end
		$display("Errors: word %0d, cmd %0d, seg %0d, protocol %0d",
			word_errors, cmd_errors, seg_errors, protocol_errors);
		if (word_errors + cmd_errors + seg_errors + protocol_errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule : command_bridge_tb

// File: sim/command_bridge_trace.txt
# Columns: command word (hex), cycles tx_full stays high before its echo (decimal)
# Word bits: [3:0] command, [17:4] x, [31:18] y
00000011 0
A5F3C2E7 5
12345678 0
DEADBEEF 12
0F0F0F0F 3
F0F0F0F0 0
8001C04A 7
3C96A5D2 1
7FFFFFFF 0
80000000 14
1B2C3D4E 2
C0FFEE15 9
55AA33CC 0
0123ABCD 4
9E8D7C6B 0
6A7B8C9D 11
BADC0DE3 0
4D5E6F70 6
E1E2E3E4 0
2F3A4B5C 13
77665544 1
ABCDEF01 0
13579BDF 8
2468ACE0 0
FEDCBA98 10
31415926 0
27182818 3
FFFFFFFF 14

// File: command_bridge.f
source/bridge_pkg.sv
source/hex_digit.sv
source/hps_fifo_reader.sv
source/hps_fifo_writer.sv
source/command_display.sv
source/command_bridge_top.sv
sim/command_bridge_tb.sv

// File: Makefile
SIM      = verilator
FLAGS    = --timing
TOP      = command_bridge_tb
FILELIST = command_bridge.f
OBJ_DIR  = obj_dir

.PHONY: lint sim clean

# Static checks on RTL and testbench
lint:
	$(SIM) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# Build, run, and fail unless the pass line shows up
sim:
	$(SIM) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q '^>>> PASS$$'

clean:
	rm -rf $(OBJ_DIR)
